/* design/csr_pkg.sv */
// Machine-mode CSR definitions
package csr_pkg;

    localparam int XLEN   = 32;                 // data width
    localparam int TIME_W = 64;                 // mtime / mtimecmp width

    // implemented CSR addresses, everything else reads zero
    typedef enum logic [11:0] {
        CSR_MSTATUS  = 12'h300,
        CSR_MISA     = 12'h301,
        CSR_MIE      = 12'h304,
        CSR_MTVEC    = 12'h305,
        CSR_MSCRATCH = 12'h340,
        CSR_MEPC     = 12'h341,
        CSR_MCAUSE   = 12'h342,
        CSR_MTVAL    = 12'h343,
        CSR_MIP      = 12'h344,
        CSR_TIME     = 12'hC01,
        CSR_TIMEH    = 12'hC81
    } csr_addr_e;

    // funct3 of the SYSTEM opcode, bit 2 selects the immediate form
    typedef enum logic [2:0] {
        CSR_NONE = 3'b000,                      // not a CSR access
        CSR_RW   = 3'b001,
        CSR_RS   = 3'b010,
        CSR_RC   = 3'b011,
        CSR_RWI  = 3'b101,
        CSR_RSI  = 3'b110,
        CSR_RCI  = 3'b111
    } csr_op_e;

    // mcause codes, interrupt codes share values with ebreak and ecall
    typedef enum logic [3:0] {
        CAUSE_ILLEGAL          = 4'd2,
        CAUSE_EBREAK           = 4'd3,
        CAUSE_LOAD_MISALIGNED  = 4'd4,
        CAUSE_STORE_MISALIGNED = 4'd6,
        CAUSE_MTI              = 4'd7,          // timer interrupt
        CAUSE_ECALL            = 4'd11
    } cause_e;
    localparam cause_e CAUSE_MSI = CAUSE_EBREAK;    // software interrupt, code 3
    localparam cause_e CAUSE_MEI = CAUSE_ECALL;     // external interrupt, code 11

    localparam logic [XLEN-1:0] MISA_VALUE = 32'h4000_0100;  // mxl=1 (rv32), I extension

    localparam int MIE_BIT  = 3;                // mstatus.mie
    localparam int MSIE_BIT = 3;                // mie / mip software
    localparam int MTIE_BIT = 7;                // mie / mip timer
    localparam int MEIE_BIT = 11;               // mie / mip external
    localparam int MPIE_BIT = 7;                // mstatus.mpie
    localparam int MPP_LSB  = 11;               // mstatus.mpp, two bits

endpackage

/* design/csr_access.sv */
// CSR read and write access
`timescale 1ns/10ps

module csr_access import csr_pkg::*; #(
    parameter logic [XLEN-1:0] TRAP_ADDRESS = '0    // mtvec reset value
) (
    input  logic              i_clk, i_rst_n,
    input  logic              i_csr_stage,          // instruction fields valid this cycle
    input  logic              i_opcode_system,
    input  csr_op_e           i_funct3,
    input  logic [11:0]       i_csr_index,
    input  logic [XLEN-1:0]   i_imm, i_rs1,
    input  logic [XLEN-1:0]   i_mstatus, i_mie, i_mip,    // owned by trap control
    input  logic [XLEN-1:0]   i_mepc, i_mcause, i_mtval,
    input  logic [TIME_W-1:0] i_mtime,
    output logic              o_wr_mstatus, o_wr_mie,
    output logic              o_wr_mepc, o_wr_mcause, o_wr_mtval,
    output logic [XLEN-1:0]   o_wr_data,            // new CSR value
    output logic [XLEN-1:0]   o_mtvec,
    output logic [XLEN-1:0]   o_csr_out             // registered pre-write value
);

    logic            csr_en;        // access happens this cycle
    logic [XLEN-1:0] csr_data;      // current value at i_csr_index
    logic [XLEN-1:0] src;           // rs1 or zero-extended immediate
    logic [XLEN-1:0] mtvec_q;
    logic [XLEN-1:0] mscratch_q;

    assign csr_en = i_opcode_system && (i_funct3 != CSR_NONE) && i_csr_stage;
    assign src    = i_funct3[2] ? i_imm : i_rs1;

    always_comb begin
        case (i_csr_index)
            CSR_MSTATUS:  csr_data = i_mstatus;
            CSR_MISA:     csr_data = MISA_VALUE;
            CSR_MIE:      csr_data = i_mie;
            CSR_MTVEC:    csr_data = mtvec_q;
            CSR_MSCRATCH: csr_data = mscratch_q;
            CSR_MEPC:     csr_data = i_mepc;
            CSR_MCAUSE:   csr_data = i_mcause;
            CSR_MTVAL:    csr_data = i_mtval;
            CSR_MIP:      csr_data = i_mip;
            CSR_TIME:     csr_data = i_mtime[XLEN-1:0];
            CSR_TIMEH:    csr_data = i_mtime[TIME_W-1:XLEN];
            default:      csr_data = '0;            // unimplemented reads zero
        endcase
    end

    always_comb begin
        case (i_funct3)
            CSR_RW, CSR_RWI: o_wr_data = src;
            CSR_RS, CSR_RSI: o_wr_data = csr_data | src;     // set bits
            CSR_RC, CSR_RCI: o_wr_data = csr_data & ~src;    // clear bits
            default:         o_wr_data = csr_data;
        endcase
    end

    // write strobes towards trap control
    assign o_wr_mstatus = csr_en && (i_csr_index == CSR_MSTATUS);
    assign o_wr_mie     = csr_en && (i_csr_index == CSR_MIE);
    assign o_wr_mepc    = csr_en && (i_csr_index == CSR_MEPC);
    assign o_wr_mcause  = csr_en && (i_csr_index == CSR_MCAUSE);
    assign o_wr_mtval   = csr_en && (i_csr_index == CSR_MTVAL);

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            mtvec_q    <= TRAP_ADDRESS;
            mscratch_q <= '0;
            o_csr_out  <= '0;
        end else begin
            if (csr_en && (i_csr_index == CSR_MTVEC)) mtvec_q <= o_wr_data;
            if (csr_en && (i_csr_index == CSR_MSCRATCH)) mscratch_q <= o_wr_data;
            if (csr_en) o_csr_out <= csr_data;      // old value goes to rd
        end
    end

    assign o_mtvec = mtvec_q;

    // read result is only refreshed by an access
    a_csr_out_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !csr_en |=> $stable(o_csr_out));

endmodule

/* design/csr_exception_detect.sv */
// Synchronous exception detection
`timescale 1ns/10ps

module csr_exception_detect import csr_pkg::*; (
    input  csr_op_e         i_funct3,           // access size for loads and stores
    input  logic            i_opcode_load, i_opcode_store,
    input  logic [XLEN-1:0] i_alu_sum,          // effective address
    input  logic            i_is_inst_illegal, i_is_ecall, i_is_ebreak,
    output logic            o_exception,
    output cause_e          o_exc_cause,
    output logic            o_addr_fault        // chosen exception is a misaligned access
);

    logic half_acc, word_acc, mis_addr;
    logic load_mis, store_mis;

    assign half_acc  = (i_funct3[1:0] == 2'b01);
    assign word_acc  = (i_funct3[1:0] == 2'b10);
    assign mis_addr  = (half_acc && i_alu_sum[0]) || (word_acc && (i_alu_sum[1:0] != 2'b00));
    assign load_mis  = i_opcode_load && mis_addr;
    assign store_mis = i_opcode_store && mis_addr;

    assign o_exception = i_is_inst_illegal || i_is_ecall || i_is_ebreak || load_mis || store_mis;

    always_comb begin
        o_addr_fault = 1'b0;
        if (i_is_inst_illegal)  o_exc_cause = CAUSE_ILLEGAL;
        else if (i_is_ecall)    o_exc_cause = CAUSE_ECALL;
        else if (i_is_ebreak)   o_exc_cause = CAUSE_EBREAK;
        else if (load_mis) begin
            o_exc_cause  = CAUSE_LOAD_MISALIGNED;
            o_addr_fault = 1'b1;
        end else begin
            o_exc_cause  = CAUSE_STORE_MISALIGNED;  // also the idle value
            o_addr_fault = store_mis;
        end
    end

endmodule

/* design/csr_machine_timer.sv */
// Machine timer
`timescale 1ns/10ps

module csr_machine_timer import csr_pkg::*; #(
    parameter int TICK_DIV = 100000                 // clocks per mtime tick
) (
    input  logic              i_clk, i_rst_n,
    input  logic              i_mtime_wr, i_mtimecmp_wr,
    input  logic [TIME_W-1:0] i_mtime_din, i_mtimecmp_din,
    output logic [TIME_W-1:0] o_mtime,
    output logic              o_timer_irq           // mtime >= mtimecmp, one clock late
);

    localparam int PRE_W = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;

    logic [PRE_W-1:0]  presc;
    logic [TIME_W-1:0] mtime_q, mtimecmp_q;
    logic              tick;                        // prescaler wraps

    assign tick = (presc == PRE_W'(TICK_DIV - 1));

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            presc       <= '0;
            mtime_q     <= '0;
            mtimecmp_q  <= '1;                      // no interrupt out of reset
            o_timer_irq <= 1'b0;
        end else begin
            if (i_mtime_wr) begin
                mtime_q <= i_mtime_din;
                presc   <= '0;                      // restart the tick period
            end else begin
                presc <= tick ? '0 : presc + 1'b1;
                if (tick) mtime_q <= mtime_q + 1'b1;
            end
            if (i_mtimecmp_wr) mtimecmp_q <= i_mtimecmp_din;
            o_timer_irq <= (mtime_q >= mtimecmp_q); // unsigned compare
        end
    end

    assign o_mtime = mtime_q;

    a_mtime_monotonic: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !$past(i_mtime_wr) && ($past(mtime_q) != {TIME_W{1'b1}}) |-> mtime_q >= $past(mtime_q));

endmodule

/* design/csr_trap_ctrl.sv */
// Trap entry and return control
`timescale 1ns/10ps

module csr_trap_ctrl import csr_pkg::*; (
    input  logic            i_clk, i_rst_n,
    input  logic            i_csr_stage,
    input  logic            i_external_interrupt, i_software_interrupt, i_timer_irq,
    input  logic            i_exception,
    input  cause_e          i_exc_cause,
    input  logic            i_addr_fault,
    input  logic            i_is_mret,
    input  logic [XLEN-1:0] i_pc, i_alu_sum,
    input  logic            i_wr_mstatus, i_wr_mie, i_wr_mepc, i_wr_mcause, i_wr_mtval,
    input  logic [XLEN-1:0] i_wr_data,
    input  logic [XLEN-1:0] i_mtvec,
    output logic [XLEN-1:0] o_mstatus, o_mie, o_mip,
    output logic [XLEN-1:0] o_mepc, o_mcause, o_mtval,
    output logic [XLEN-1:0] o_trap_address, o_return_address,
    output logic            o_go_to_trap_q, o_return_from_trap_q
);

    logic              mstatus_mie, mstatus_mpie;
    logic              mie_msie, mie_mtie, mie_meie;
    logic              mip_msip, mip_meip;      // registered interrupt lines
    logic [XLEN-1:2]   mepc_q;                  // word aligned
    logic              mcause_int;
    logic [3:0]        mcause_code;
    logic [XLEN-1:0]   mtval_q;
    logic              pend_ext, pend_sw, pend_tmr, is_irq;
    logic              go_to_trap, do_mret;
    cause_e            irq_code, trap_cause;
    logic [XLEN-1:0]   trap_base, trap_addr;

    // pending and enabled, globally and individually
    assign pend_ext = mstatus_mie && mie_meie && mip_meip;
    assign pend_sw  = mstatus_mie && mie_msie && mip_msip;
    assign pend_tmr = mstatus_mie && mie_mtie && i_timer_irq;
    assign is_irq   = pend_ext || pend_sw || pend_tmr;

    always_comb begin
        if (pend_ext)     irq_code = CAUSE_MEI;
        else if (pend_sw) irq_code = CAUSE_MSI;
        else              irq_code = CAUSE_MTI;
    end

    assign trap_cause = is_irq ? irq_code : i_exc_cause;    // interrupts outrank exceptions
    assign go_to_trap = i_csr_stage && (is_irq || i_exception);
    assign do_mret    = i_csr_stage && i_is_mret;

    // vectored mode only redirects interrupts
    assign trap_base = {i_mtvec[XLEN-1:2], 2'b00};
    assign trap_addr = (i_mtvec[0] && is_irq) ?
                       trap_base + {{(XLEN-6){1'b0}}, irq_code, 2'b00} : trap_base;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            mstatus_mie  <= 1'b0;
            mstatus_mpie <= 1'b0;
            mie_msie     <= 1'b0;
            mie_mtie     <= 1'b0;
            mie_meie     <= 1'b0;
            mip_msip     <= 1'b0;
            mip_meip     <= 1'b0;
            mepc_q       <= '0;
            mcause_int   <= 1'b0;
            mcause_code  <= '0;
            mtval_q      <= '0;
        end else begin
            mip_msip <= i_software_interrupt;
            mip_meip <= i_external_interrupt;
            if (i_wr_mstatus) begin                 // software write beats the stack update
                mstatus_mie  <= i_wr_data[MIE_BIT];
                mstatus_mpie <= i_wr_data[MPIE_BIT];
            end else if (go_to_trap) begin
                mstatus_mpie <= mstatus_mie;
                mstatus_mie  <= 1'b0;
            end else if (do_mret) begin
                mstatus_mie  <= mstatus_mpie;
                mstatus_mpie <= 1'b1;
            end
            if (i_wr_mie) begin
                mie_msie <= i_wr_data[MSIE_BIT];
                mie_mtie <= i_wr_data[MTIE_BIT];
                mie_meie <= i_wr_data[MEIE_BIT];
            end
            if (go_to_trap) begin                   // trap beats the CSR write
                mepc_q      <= i_pc[XLEN-1:2];
                mcause_int  <= is_irq;
                mcause_code <= trap_cause;
                if (!is_irq && i_addr_fault) mtval_q <= i_alu_sum;     // faulting address
            end else begin
                if (i_wr_mepc) mepc_q <= i_wr_data[XLEN-1:2];
                if (i_wr_mcause) begin
                    mcause_int  <= i_wr_data[XLEN-1];
                    mcause_code <= i_wr_data[3:0];
                end
                if (i_wr_mtval) mtval_q <= i_wr_data;
            end
        end
    end

    // redirect outputs, sampled only in the CSR stage
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_go_to_trap_q       <= 1'b0;
            o_return_from_trap_q <= 1'b0;
            o_trap_address       <= '0;
            o_return_address     <= '0;
        end else if (i_csr_stage) begin
            o_go_to_trap_q       <= go_to_trap;
            o_return_from_trap_q <= do_mret;
            o_trap_address       <= trap_addr;
            o_return_address     <= o_mepc;
        end
    end

    always_comb begin
        o_mstatus                        = '0;
        o_mstatus[MIE_BIT]               = mstatus_mie;
        o_mstatus[MPIE_BIT]              = mstatus_mpie;
        o_mstatus[MPP_LSB+1:MPP_LSB]     = 2'b11;   // machine mode only
        o_mie                            = '0;
        o_mie[MSIE_BIT]                  = mie_msie;
        o_mie[MTIE_BIT]                  = mie_mtie;
        o_mie[MEIE_BIT]                  = mie_meie;
        o_mip                            = '0;
        o_mip[MSIE_BIT]                  = mip_msip;
        o_mip[MTIE_BIT]                  = i_timer_irq;   // already registered in the timer
        o_mip[MEIE_BIT]                  = mip_meip;
    end

    assign o_mepc   = {mepc_q, 2'b00};
    assign o_mcause = {mcause_int, {(XLEN-5){1'b0}}, mcause_code};
    assign o_mtval  = mtval_q;

    a_trap_from_stage: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        $rose(o_go_to_trap_q) |-> $past(i_csr_stage));

endmodule

/* design/csr_top.sv */
// Machine-mode CSR unit
`timescale 1ns/10ps

module csr_top import csr_pkg::*; #(
    parameter int              TICK_DIV     = 100000,   // clocks per mtime tick
    parameter logic [XLEN-1:0] TRAP_ADDRESS = '0        // mtvec reset value
) (
    input  logic              i_clk, i_rst_n,
    input  logic              i_csr_stage,
    input  logic              i_external_interrupt, i_software_interrupt,
    input  logic              i_mtime_wr, i_mtimecmp_wr,
    input  logic [TIME_W-1:0] i_mtime_din, i_mtimecmp_din,
    input  logic              i_is_inst_illegal, i_is_ecall, i_is_ebreak, i_is_mret,
    input  logic              i_opcode_load, i_opcode_store, i_opcode_system,
    input  csr_op_e           i_funct3,
    input  logic [11:0]       i_csr_index,
    input  logic [XLEN-1:0]   i_imm, i_rs1, i_alu_sum, i_pc,
    output logic [XLEN-1:0]   o_csr_out,
    output logic [XLEN-1:0]   o_return_address, o_trap_address,
    output logic              o_go_to_trap_q, o_return_from_trap_q
);

    logic              wr_mstatus, wr_mie, wr_mepc, wr_mcause, wr_mtval;
    logic [XLEN-1:0]   wr_data, mtvec;
    logic [XLEN-1:0]   mstatus, mie, mip, mepc, mcause, mtval;
    logic [TIME_W-1:0] mtime;
    logic              timer_irq;
    logic              exception, addr_fault;
    cause_e            exc_cause;

    csr_access #(.TRAP_ADDRESS(TRAP_ADDRESS)) access_i (
        .i_clk(i_clk), .i_rst_n(i_rst_n),
        .i_csr_stage(i_csr_stage), .i_opcode_system(i_opcode_system),
        .i_funct3(i_funct3), .i_csr_index(i_csr_index),
        .i_imm(i_imm), .i_rs1(i_rs1),
        .i_mstatus(mstatus), .i_mie(mie), .i_mip(mip),
        .i_mepc(mepc), .i_mcause(mcause), .i_mtval(mtval),
        .i_mtime(mtime),
        .o_wr_mstatus(wr_mstatus), .o_wr_mie(wr_mie),
        .o_wr_mepc(wr_mepc), .o_wr_mcause(wr_mcause), .o_wr_mtval(wr_mtval),
        .o_wr_data(wr_data), .o_mtvec(mtvec), .o_csr_out(o_csr_out)
    );

    csr_exception_detect exc_i (
        .i_funct3(i_funct3),
        .i_opcode_load(i_opcode_load), .i_opcode_store(i_opcode_store),
        .i_alu_sum(i_alu_sum),
        .i_is_inst_illegal(i_is_inst_illegal), .i_is_ecall(i_is_ecall),
        .i_is_ebreak(i_is_ebreak),
        .o_exception(exception), .o_exc_cause(exc_cause), .o_addr_fault(addr_fault)
    );

    csr_machine_timer #(.TICK_DIV(TICK_DIV)) timer_i (
        .i_clk(i_clk), .i_rst_n(i_rst_n),
        .i_mtime_wr(i_mtime_wr), .i_mtimecmp_wr(i_mtimecmp_wr),
        .i_mtime_din(i_mtime_din), .i_mtimecmp_din(i_mtimecmp_din),
        .o_mtime(mtime), .o_timer_irq(timer_irq)
    );

    csr_trap_ctrl trap_i (
        .i_clk(i_clk), .i_rst_n(i_rst_n), .i_csr_stage(i_csr_stage),
        .i_external_interrupt(i_external_interrupt),
        .i_software_interrupt(i_software_interrupt),
        .i_timer_irq(timer_irq),
        .i_exception(exception), .i_exc_cause(exc_cause), .i_addr_fault(addr_fault),
        .i_is_mret(i_is_mret), .i_pc(i_pc), .i_alu_sum(i_alu_sum),
        .i_wr_mstatus(wr_mstatus), .i_wr_mie(wr_mie), .i_wr_mepc(wr_mepc),
        .i_wr_mcause(wr_mcause), .i_wr_mtval(wr_mtval), .i_wr_data(wr_data),
        .i_mtvec(mtvec),
        .o_mstatus(mstatus), .o_mie(mie), .o_mip(mip),
        .o_mepc(mepc), .o_mcause(mcause), .o_mtval(mtval),
        .o_trap_address(o_trap_address), .o_return_address(o_return_address),
        .o_go_to_trap_q(o_go_to_trap_q), .o_return_from_trap_q(o_return_from_trap_q)
    );

endmodule

/* verif/csr_tb.sv */
// CSR unit testbench
`timescale 1ns/10ps

module csr_tb import csr_pkg::*; ();

    localparam int TICK_DIV   = 10;
    localparam int MAX_CYCLES = 6000;               // ~2000 used by the test sequence

    logic              i_clk, i_rst_n, i_csr_stage;
    logic              i_external_interrupt, i_software_interrupt;
    logic              i_mtime_wr, i_mtimecmp_wr;
    logic [63:0]       i_mtime_din, i_mtimecmp_din;
    logic              i_is_inst_illegal, i_is_ecall, i_is_ebreak, i_is_mret;
    logic              i_opcode_load, i_opcode_store, i_opcode_system;
    csr_op_e           i_funct3;
    logic [11:0]       i_csr_index;
    logic [31:0]       i_imm, i_rs1, i_alu_sum, i_pc;
    logic [31:0]       o_csr_out, o_return_address, o_trap_address;
    logic              o_go_to_trap_q, o_return_from_trap_q;

    integer            seed, errors, checks;
    integer            cycles = 0;
    logic              m_mie_g, m_mpie;             // model of mstatus.mie / mpie
    logic [31:0]       m_mie, m_mtvec, m_mscratch, m_mepc, m_mcause, m_mtval, m_mip;
    logic [31:0]       r, rd, delta;
    logic [11:0]       a;
    logic [63:0]       t_base;
    logic [11:0]       addr_list [11] = '{CSR_MSTATUS, CSR_MISA, CSR_MIE, CSR_MTVEC, CSR_MSCRATCH,
                                          CSR_MEPC, CSR_MCAUSE, CSR_MTVAL, CSR_MIP, 12'h3A0, 12'h7C0};
    csr_op_e           op_list [6] = '{CSR_RW, CSR_RS, CSR_RC, CSR_RWI, CSR_RSI, CSR_RCI};

    csr_top #(.TICK_DIV(TICK_DIV)) dut_i (.*);

    initial begin
        i_clk = 1'b0;
        forever #4 i_clk = ~i_clk;                  // 8 ns period
    end

    always @(posedge i_clk) begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("errors: %0d of %0d checks", errors, checks);
            $display("Regression failed");
            $finish;
        end
    end

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks = checks + 1;
        if (exp !== act) begin
            errors = errors + 1;
            $display("error %s: expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic drive_idle();
        i_csr_stage <= 1'b0;
        i_opcode_system <= 1'b0;
        i_opcode_load <= 1'b0;
        i_opcode_store <= 1'b0;
        i_is_inst_illegal <= 1'b0;
        i_is_ecall <= 1'b0;
        i_is_ebreak <= 1'b0;
        i_is_mret <= 1'b0;
        i_funct3 <= CSR_NONE;
        i_csr_index <= '0;
        i_imm <= '0;
        i_rs1 <= '0;
        i_alu_sum <= '0;
        i_pc <= '0;
        i_external_interrupt <= 1'b0;
        i_software_interrupt <= 1'b0;
        i_mtime_wr <= 1'b0;
        i_mtimecmp_wr <= 1'b0;
        i_mtime_din <= '0;
        i_mtimecmp_din <= '0;
    endtask

    function automatic logic [31:0] model_read(input logic [11:0] addr);
        case (addr)
            CSR_MSTATUS:  model_read = {19'b0, 2'b11, 3'b0, m_mpie, 3'b0, m_mie_g, 3'b0};
            CSR_MISA:     model_read = MISA_VALUE;
            CSR_MIE:      model_read = m_mie;
            CSR_MTVEC:    model_read = m_mtvec;
            CSR_MSCRATCH: model_read = m_mscratch;
            CSR_MEPC:     model_read = m_mepc;
            CSR_MCAUSE:   model_read = m_mcause;
            CSR_MTVAL:    model_read = m_mtval;
            CSR_MIP:      model_read = m_mip;
            default:      model_read = '0;          // unimplemented reads zero
        endcase
    endfunction

    task automatic model_write(input logic [11:0] addr, input logic [31:0] v);
        case (addr)
            CSR_MSTATUS: begin
                m_mie_g = v[3];
                m_mpie  = v[7];
            end
            CSR_MIE:      m_mie = v & 32'h888;      // msie, mtie, meie only
            CSR_MTVEC:    m_mtvec = v;
            CSR_MSCRATCH: m_mscratch = v;
            CSR_MEPC:     m_mepc = {v[31:2], 2'b00};
            CSR_MCAUSE:   m_mcause = {v[31], 27'b0, v[3:0]};
            CSR_MTVAL:    m_mtval = v;
            default: ;                              // read-only or unimplemented
        endcase
    endtask

    // one CSR instruction returning the registered read value
    task automatic access(input csr_op_e op, input logic [11:0] addr, input logic [31:0] rs1,
                          input logic [31:0] imm, output logic [31:0] rdata);
        @(posedge i_clk);
        i_csr_stage <= 1'b1;
        i_opcode_system <= 1'b1;
        i_funct3 <= op;
        i_csr_index <= addr;
        i_rs1 <= rs1;
        i_imm <= imm;
        @(posedge i_clk);
        drive_idle();
        @(negedge i_clk);
        rdata = o_csr_out;
        check("no trap on csr access", 32'h0, 32'(o_go_to_trap_q));
        check("no mret on csr access", 32'h0, 32'(o_return_from_trap_q));
    endtask

    task automatic csr_op(input csr_op_e op, input logic [11:0] addr, input logic [31:0] rs1,
                          input logic [31:0] imm);
        logic [31:0] exp, src, nv, rdata;
        exp = model_read(addr);
        src = op[2] ? imm : rs1;
        case (op)
            CSR_RW, CSR_RWI: nv = src;
            CSR_RS, CSR_RSI: nv = exp | src;
            default:         nv = exp & ~src;
        endcase
        model_write(addr, nv);
        access(op, addr, rs1, imm, rdata);
        check($sformatf("csr read %h", addr), exp, rdata);
    endtask

    // one stage cycle with trap sources where ext/sw give the registered mip bits
    task automatic stage_step(input logic ill, input logic ec, input logic eb, input logic ld,
                              input logic st, input logic [2:0] f3, input logic [31:0] alu,
                              input logic [31:0] pc, input logic ret, input logic ext,
                              input logic sw, input logic tmr);
        logic        mis, lm, sm, pe, ps, pt, irq, e_go;
        logic [3:0]  code;
        logic [31:0] e_addr, e_ret;
        mis  = (f3[1:0] == 2'd1 && alu[0]) || (f3[1:0] == 2'd2 && alu[1:0] != 2'd0);
        lm   = ld && mis;
        sm   = st && mis;
        pe   = m_mie_g && m_mie[11] && ext;
        ps   = m_mie_g && m_mie[3] && sw;
        pt   = m_mie_g && m_mie[7] && tmr;
        irq  = pe || ps || pt;
        e_go = irq || ill || ec || eb || lm || sm;
        if (irq) code = pe ? 4'd11 : (ps ? 4'd3 : 4'd7);
        else if (ill) code = 4'd2;
        else if (ec) code = 4'd11;
        else if (eb) code = 4'd3;
        else code = lm ? 4'd4 : 4'd6;
        e_addr = {m_mtvec[31:2], 2'b00} + ((m_mtvec[0] && irq) ? {26'b0, code, 2'b00} : 32'h0);
        e_ret  = m_mepc;                            // mepc before this step
        @(posedge i_clk);
        i_csr_stage <= 1'b1;
        i_is_inst_illegal <= ill;
        i_is_ecall <= ec;
        i_is_ebreak <= eb;
        i_opcode_load <= ld;
        i_opcode_store <= st;
        i_funct3 <= csr_op_e'(f3);
        i_alu_sum <= alu;
        i_pc <= pc;
        i_is_mret <= ret;
        i_external_interrupt <= 1'b0;               // lines drop, only mip still holds them
        i_software_interrupt <= 1'b0;
        @(posedge i_clk);
        drive_idle();
        @(negedge i_clk);
        if (e_go) begin
            m_mepc   = {pc[31:2], 2'b00};
            m_mcause = {irq, 27'b0, code};
            if (!irq && !ill && !ec && !eb) m_mtval = alu;  // misaligned address
            m_mpie   = m_mie_g;
            m_mie_g  = 1'b0;
        end else if (ret) begin
            m_mie_g = m_mpie;
            m_mpie  = 1'b1;
        end
        check("trap taken", 32'(e_go), 32'(o_go_to_trap_q));
        check("trap address", e_addr, o_trap_address);
        check("mret pulse", 32'(ret), 32'(o_return_from_trap_q));
        check("return address", e_ret, o_return_address);
    endtask

    task automatic timer_write(input logic cmp, input logic [63:0] v);
        @(posedge i_clk);
        if (cmp) begin
            i_mtimecmp_wr <= 1'b1;
            i_mtimecmp_din <= v;
        end else begin
            i_mtime_wr <= 1'b1;
            i_mtime_din <= v;
        end
        @(posedge i_clk);
        i_mtime_wr <= 1'b0;
        i_mtimecmp_wr <= 1'b0;
    endtask

    initial begin
        seed = 83210;
        errors = 0;
        checks = 0;
        m_mie_g = 1'b0;
        m_mpie = 1'b0;
        m_mie = '0;
        m_mtvec = '0;                               // TRAP_ADDRESS default
        m_mscratch = '0;
        m_mepc = '0;
        m_mcause = '0;
        m_mtval = '0;
        m_mip = '0;
        i_rst_n = 1'b0;
        drive_idle();
        repeat (8) @(posedge i_clk);
        i_rst_n <= 1'b1;
        @(negedge i_clk);
        check("reset csr_out", 32'h0, o_csr_out);
        check("reset trap flag", 32'h0, 32'(o_go_to_trap_q));
        check("reset mret flag", 32'h0, 32'(o_return_from_trap_q));
        check("reset trap address", 32'h0, o_trap_address);
        check("reset return address", 32'h0, o_return_address);
        repeat (300) begin                          // random CSR instructions
            r = $random(seed);
            a = (r[3:0] < 4'd11) ? addr_list[r[3:0]] : {2'b01, r[29:20]};
            csr_op(op_list[r[6:4] % 3'd6], a, $random(seed), {27'b0, r[11:7]});
        end
        repeat (60) begin                           // exceptions with mtval on misaligned only
            r = $random(seed);
            stage_step(r[2:0] == 3'd0, r[5:3] == 3'd0, r[8:6] == 3'd0, r[10:9] == 2'd1,
                       r[10:9] == 2'd2, {1'b0, r[12:11]}, $random(seed), $random(seed),
                       1'b0, 1'b0, 1'b0, 1'b0);
            csr_op(CSR_RS, CSR_MEPC, 32'h0, 32'h0);
            csr_op(CSR_RS, CSR_MCAUSE, 32'h0, 32'h0);
            csr_op(CSR_RS, CSR_MTVAL, 32'h0, 32'h0);
        end
        repeat (60) begin                           // interrupt gating and priority
            r = $random(seed);
            csr_op(CSR_RW, CSR_MSTATUS, (r[1:0] != 2'd0) ? 32'h8 : 32'h0, 32'h0);
            csr_op(CSR_RW, CSR_MIE, $random(seed), 32'h0);
            csr_op(CSR_RW, CSR_MTVEC, $random(seed), 32'h0);
            @(posedge i_clk);
            i_external_interrupt <= r[2];
            i_software_interrupt <= r[3];
            stage_step(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 3'd0, 32'h0, $random(seed),
                       1'b0, r[2], r[3], 1'b0);
            csr_op(CSR_RS, CSR_MCAUSE, 32'h0, 32'h0);
        end
        repeat (20) begin                           // mret restores the stack
            csr_op(CSR_RW, CSR_MSTATUS, $random(seed), 32'h0);
            csr_op(CSR_RW, CSR_MEPC, $random(seed), 32'h0);
            stage_step(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 3'd0, 32'h0, $random(seed),
                       1'b1, 1'b0, 1'b0, 1'b0);
            csr_op(CSR_RS, CSR_MSTATUS, 32'h0, 32'h0);
        end
        r = $random(seed);
        t_base = {33'h0, r[30:0]};                  // no carry into timeh
        timer_write(1'b0, t_base);
        repeat (5 * TICK_DIV) @(posedge i_clk);
        access(CSR_RS, CSR_TIME, 32'h0, 32'h0, rd);
        delta = rd - t_base[31:0];
        checks = checks + 1;
        if (delta < 4 || delta > 6) begin          // five ticks give or take one
            errors = errors + 1;
            $display("error timer ticks: expected 5 actual %0d", delta);
        end
        access(CSR_RS, CSR_TIMEH, 32'h0, 32'h0, rd);
        check("timeh", 32'h0, rd);
        csr_op(CSR_RW, CSR_MIE, 32'h80, 32'h0);
        csr_op(CSR_RW, CSR_MSTATUS, 32'h8, 32'h0);
        csr_op(CSR_RW, CSR_MTVEC, $random(seed), 32'h0);
        timer_write(1'b1, t_base + 64'd1000);     // compare well above mtime
        repeat (4) @(posedge i_clk);
        stage_step(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 3'd0, 32'h0, $random(seed),
                   1'b0, 1'b0, 1'b0, 1'b0);
        timer_write(1'b1, t_base);                  // now at or below mtime
        repeat (3) @(posedge i_clk);
        m_mip = 32'h80;                             // mtip pending
        stage_step(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 3'd0, 32'h0, $random(seed),
                   1'b0, 1'b0, 1'b0, 1'b1);
        csr_op(CSR_RS, CSR_MCAUSE, 32'h0, 32'h0);
        csr_op(CSR_RS, CSR_MIP, 32'h0, 32'h0);
        timer_write(1'b1, '1);
        m_mip = '0;
        repeat (3) @(posedge i_clk);
        csr_op(CSR_RS, CSR_MIP, 32'h0, 32'h0);     // mtip gone again
        $display("errors: %0d of %0d checks", errors, checks);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

/* vlog.f */
design/csr_pkg.sv
design/csr_access.sv
design/csr_exception_detect.sv
design/csr_machine_timer.sv
design/csr_trap_ctrl.sv
design/csr_top.sv
verif/csr_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -j 0 --top-module csr_tb -f vlog.f -o csr_sim
./obj_dir/csr_sim > sim.log 2>&1
cat sim.log
if grep -q "^Regression passed$" sim.log; then
    exit 0
fi
exit 1
